//--- ofdm_equalizer.f
design/ofdm_pkg.sv
design/eq_ctrl_pkg.sv
design/iq_stream_if.sv
design/channel_estimator.sv
design/conj_mult.sv
design/serial_divider.sv
design/equalizer_ctrl.sv
design/ofdm_equalizer.sv
verification/eq_clock_gen.sv
verification/tb_ofdm_equalizer.sv

//--- verification/tb_ofdm_equalizer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ofdm_equalizer;
    import ofdm_pkg::*;
    import eq_ctrl_pkg::*;

    typedef enum int {CH_RANDOM, CH_ZERO, CH_TINY} chan_kind_t;

    typedef struct {
        string      name;
        chan_kind_t kind;
        int         num_symbols;
        bit         random_ready;
        bit         drop_mid_symbol;
    } test_row_t;

    localparam int NUM_TESTS   = 5;
    localparam int PARTIAL_LEN = 10;
    localparam int DATA_SPAN   = 16000;
    // cycles from accepting a data sample to its out_valid_o
    localparam int OUT_LATENCY = 4 + DIV_LATENCY;

    test_row_t tests [NUM_TESTS] = '{
        '{"random_channel", CH_RANDOM, 2, 1'b0, 1'b0},
        '{"backpressure",   CH_RANDOM, 2, 1'b1, 1'b0},
        '{"zero_channel",   CH_ZERO,   1, 1'b0, 1'b0},
        '{"tiny_channel",   CH_TINY,   1, 1'b1, 1'b0},
        '{"flush_restart",  CH_RANDOM, 1, 1'b0, 1'b1}
    };

    logic       clock;
    logic       reset;
    logic       enable_i;
    logic       in_valid_i;
    logic       in_ready_o;
    iq_sample_t in_sample_i;
    logic       out_valid_o;
    logic       out_ready_i;
    iq_sample_t out_sample_o;
    logic       out_last_o;

    iq_sample_t chan_est [NUM_SC];
    iq_sample_t exp_q [$];
    bit         exp_last_q [$];
    int         exp_cycle_q [$];
    iq_sample_t mon_sample;
    bit         mon_last;
    bit         random_ready;
    bit         valid_seen = 1'b0;
    int         accept_cycle = 0;
    int         error_count = 0;
    int         check_count = 0;
    int         test_errors = 0;
    int         out_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    eq_clock_gen clock_gen_i (
        .clock_o (clock),
        .reset_o (reset)
    );

    ofdm_equalizer dut_i (
        .clock, .reset, .enable_i,
        .in_valid_i, .in_ready_o, .in_sample_i,
        .out_valid_o, .out_ready_i, .out_sample_o, .out_last_o
    );

    function automatic logic signed [IQ_W-1:0] rand_comp(int span);
        int v;
        v = int'($urandom_range(2 * span, 0)) - span;
        return v[IQ_W-1:0];
    endfunction

    // average of the two training values, sign flipped where the reference is -1
    function automatic iq_sample_t estimate(iq_sample_t a, iq_sample_t b, int k);
        int         si;
        int         sq;
        iq_sample_t h;
        si = (int'(a.i) + int'(b.i)) >>> 1;
        sq = (int'(a.q) + int'(b.q)) >>> 1;
        if (LTS_REF[k]) begin
            si = -si;
            sq = -sq;
        end
        h.i = si[IQ_W-1:0];
        h.q = sq[IQ_W-1:0];
        return h;
    endfunction

    // truncates toward zero, clamps to the sample range, zero for a zero divisor
    function automatic logic signed [IQ_W-1:0] scale_divide(longint prod, longint mag);
        longint q;
        longint max_v = 2 ** (IQ_W - 1) - 1;
        longint min_v = -(2 ** (IQ_W - 1));
        if (mag == 0) begin
            return '0;
        end
        q = (prod <<< CONS_SCALE_SHIFT) / mag;
        if (q > max_v) begin
            q = max_v;
        end else if (q < min_v) begin
            q = min_v;
        end
        return q[IQ_W-1:0];
    endfunction

    function automatic iq_sample_t equalize(iq_sample_t x, iq_sample_t h);
        longint     re;
        longint     im;
        longint     mag;
        iq_sample_t y;
        re  = longint'(x.i) * h.i + longint'(x.q) * h.q;
        im  = longint'(x.q) * h.i - longint'(x.i) * h.q;
        mag = longint'(h.i) * h.i + longint'(h.q) * h.q;
        y.i = scale_divide(re, mag);
        y.q = scale_divide(im, mag);
        return y;
    endfunction

    task automatic send_sample(iq_sample_t s);
        bit taken;
        in_valid_i  = 1'b1;
        in_sample_i = s;
        do begin
            @(negedge clock);
            taken = in_ready_o;
            if (taken) begin
                accept_cycle = cycle_count;
            end
            @(posedge clock);
            #2;
        end while (!taken);
        in_valid_i = 1'b0;
    endtask

    task automatic send_lts(chan_kind_t kind);
        iq_sample_t first [NUM_SC];
        iq_sample_t second [NUM_SC];
        for (int k = 0; k < NUM_SC; k++) begin
            first[k].i = (kind == CH_TINY) ? rand_comp(2) : rand_comp(DATA_SPAN);
            first[k].q = (kind == CH_TINY) ? rand_comp(2) : rand_comp(DATA_SPAN);
            case (kind)
                CH_ZERO: begin
                    second[k].i = -first[k].i;
                    second[k].q = -first[k].q;
                end
                CH_TINY: second[k] = first[k];
                default: begin
                    second[k].i = rand_comp(DATA_SPAN);
                    second[k].q = rand_comp(DATA_SPAN);
                end
            endcase
            chan_est[k] = estimate(first[k], second[k], k);
        end
        foreach (first[k]) send_sample(first[k]);
        foreach (second[k]) send_sample(second[k]);
        // one idle cycle while the estimate completes
        @(posedge clock);
        #2;
    endtask

    task automatic send_symbol(int count);
        iq_sample_t x;
        int         data_idx;
        data_idx = 0;
        for (int k = 0; k < count; k++) begin
            x.i = rand_comp(DATA_SPAN);
            x.q = rand_comp(DATA_SPAN);
            send_sample(x);
            // a cut-short symbol loses its final sample to the flush
            if (DATA_SC_MASK[k] && (count == NUM_SC || k < count - 1)) begin
                exp_q.push_back(equalize(x, chan_est[k]));
                exp_last_q.push_back(data_idx == NUM_DATA_SC - 1);
                exp_cycle_q.push_back(accept_cycle + OUT_LATENCY);
                data_idx++;
            end
        end
    endtask

    task automatic restart_core();
        enable_i = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        enable_i = 1'b1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        #2;
    endtask

    always @(posedge clock) begin
        #2;
        out_ready_i = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    // outputs are stable around the falling edge
    always @(negedge clock) begin
        if (!reset && exp_cycle_q.size() != 0) begin
            assert (!in_ready_o) else begin
                $display("in_ready_o went high while a data sample was still in flight");
                error_count++;
                test_errors++;
            end
        end
        if (!reset && out_valid_o && !valid_seen) begin
            valid_seen = 1'b1;
            if (exp_cycle_q.size() != 0) begin
                assert (cycle_count == exp_cycle_q[0]) else begin
                    $display("MISMATCH out_valid_o rise cycle: got %h expected %h",
                             cycle_count, exp_cycle_q[0]);
                    error_count++;
                    test_errors++;
                end
            end
        end
        if (!reset && out_valid_o && out_ready_i) begin
            valid_seen = 1'b0;
            assert (exp_q.size() != 0) else begin
                $display("output %h appeared with no sample pending", out_sample_o);
                error_count++;
                test_errors++;
            end
            if (exp_q.size() != 0) begin
                mon_sample = exp_q.pop_front();
                mon_last   = exp_last_q.pop_front();
                void'(exp_cycle_q.pop_front());
                check_count++;
                out_count++;
                assert (out_sample_o == mon_sample) else begin
                    $display("MISMATCH out_sample_o: got %h expected %h",
                             out_sample_o, mon_sample);
                    error_count++;
                    test_errors++;
                end
                assert (out_last_o == mon_last) else begin
                    $display("MISMATCH out_last_o: got %h expected %h", out_last_o, mon_last);
                    error_count++;
                    test_errors++;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d outputs still missing",
                     cycle_count, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int total;
        void'($urandom(2732));
        enable_i     = 1'b1;
        in_valid_i   = 1'b0;
        in_sample_i  = '0;
        out_ready_i  = 1'b0;
        random_ready = 1'b0;
        total = 0;
        foreach (tests[t]) begin
            total += 2 * NUM_SC + tests[t].num_symbols * NUM_SC;
            total += tests[t].drop_mid_symbol ? PARTIAL_LEN : 0;
        end
        cycle_limit = total * (DIV_LATENCY + 8) + 1000;
        @(negedge reset);
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors  = 0;
            out_count    = 0;
            random_ready = tests[t].random_ready;
            if (tests[t].drop_mid_symbol) begin
                send_symbol(PARTIAL_LEN);
            end
            if (t > 0) begin
                restart_core();
            end
            send_lts(tests[t].kind);
            repeat (tests[t].num_symbols) send_symbol(NUM_SC);
            wait_drain();
            $display("test %0d %s: %0d outputs, %0d errors",
                     t, tests[t].name, out_count, test_errors);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/eq_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module eq_clock_gen (
    output logic clock_o,
    output logic reset_o
);
    localparam real HALF_PERIOD_NS = 10.0;
    localparam int  RESET_CYCLES   = 10;

    initial begin
        clock_o = 1'b0;
        forever #(HALF_PERIOD_NS) clock_o = ~clock_o;
    end

    // reset drops just after an edge, like every other driven input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        #2;
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- design/ofdm_equalizer.sv
`timescale 1ns/1ps
`default_nettype none

module ofdm_equalizer (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  enable_i,
    input  wire logic                  in_valid_i,
    output logic                       in_ready_o,
    input  wire ofdm_pkg::iq_sample_t  in_sample_i,
    output logic                       out_valid_o,
    input  wire logic                  out_ready_i,
    output ofdm_pkg::iq_sample_t       out_sample_o,
    output logic                       out_last_o
);
    import ofdm_pkg::*;

    iq_stream_if lts_stream ();

    logic                       flush;
    logic                       chan_valid;
    logic [SC_IDX_W-1:0]        rd_index;
    iq_sample_t                 chan;
    iq_sample_t                 mult_sample;
    iq_sample_t                 mult_chan;
    logic                       mult_start;
    logic                       mult_done;
    logic signed [PROD_W-1:0]   prod_i;
    logic signed [PROD_W-1:0]   prod_q;
    logic signed [PROD_W-1:0]   mag_sq;
    logic                       div_start;
    logic                       div_done;
    logic signed [QUO_W-1:0]    dividend_i;
    logic signed [QUO_W-1:0]    dividend_q;
    logic signed [PROD_W-1:0]   divisor;
    logic signed [IQ_W-1:0]     quotient_i;
    logic signed [IQ_W-1:0]     quotient_q;
    logic                       div_busy;

    equalizer_ctrl ctrl_i (
        .clock, .reset, .enable_i,
        .in_valid_i, .in_ready_o, .in_sample_i,
        .lts           (lts_stream.source),
        .chan_valid_i  (chan_valid),
        .rd_index_o    (rd_index),
        .chan_i        (chan),
        .mult_start_o  (mult_start),
        .mult_sample_o (mult_sample),
        .mult_chan_o   (mult_chan),
        .mult_done_i   (mult_done),
        .prod_i_i      (prod_i),
        .prod_q_i      (prod_q),
        .mag_sq_i      (mag_sq),
        .div_start_o   (div_start),
        .dividend_i_o  (dividend_i),
        .dividend_q_o  (dividend_q),
        .divisor_o     (divisor),
        .div_done_i    (div_done),
        .quotient_i_i  (quotient_i),
        .quotient_q_i  (quotient_q),
        .flush_o       (flush),
        .out_valid_o, .out_ready_i, .out_sample_o, .out_last_o
    );

    channel_estimator chan_est_i (
        .clock, .reset,
        .flush_i      (flush),
        .lts          (lts_stream.sink),
        .rd_index_i   (rd_index),
        .chan_o       (chan),
        .chan_valid_o (chan_valid)
    );

    conj_mult mult_i (
        .clock, .reset,
        .start_i  (mult_start),
        .sample_i (mult_sample),
        .chan_i   (mult_chan),
        .prod_i_o (prod_i),
        .prod_q_o (prod_q),
        .mag_sq_o (mag_sq),
        .done_o   (mult_done)
    );

    serial_divider div_i_i (
        .clock, .reset,
        .start_i    (div_start),
        .dividend_i (dividend_i),
        .divisor_i  (divisor),
        .quotient_o (quotient_i),
        .busy_o     (div_busy),
        .done_o     (div_done)
    );

    // runs in lockstep with the I divider
    serial_divider div_q_i (
        .clock, .reset,
        .start_i    (div_start),
        .dividend_i (dividend_q),
        .divisor_i  (divisor),
        .quotient_o (quotient_q),
        .busy_o     (),
        .done_o     ()
    );

    assert property (@(posedge clock) disable iff (reset) div_start |-> !div_busy);

endmodule

`default_nettype wire

//--- design/equalizer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module equalizer_ctrl (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic                               enable_i,
    input  wire logic                               in_valid_i,
    output logic                                    in_ready_o,
    input  wire ofdm_pkg::iq_sample_t               in_sample_i,
    iq_stream_if.source                             lts,
    input  wire logic                               chan_valid_i,
    output logic [ofdm_pkg::SC_IDX_W-1:0]           rd_index_o,
    input  wire ofdm_pkg::iq_sample_t               chan_i,
    output logic                                    mult_start_o,
    output ofdm_pkg::iq_sample_t                    mult_sample_o,
    output ofdm_pkg::iq_sample_t                    mult_chan_o,
    input  wire logic                               mult_done_i,
    input  wire logic signed [ofdm_pkg::PROD_W-1:0] prod_i_i,
    input  wire logic signed [ofdm_pkg::PROD_W-1:0] prod_q_i,
    input  wire logic signed [ofdm_pkg::PROD_W-1:0] mag_sq_i,
    output logic                                    div_start_o,
    output logic signed [ofdm_pkg::QUO_W-1:0]       dividend_i_o,
    output logic signed [ofdm_pkg::QUO_W-1:0]       dividend_q_o,
    output logic signed [ofdm_pkg::PROD_W-1:0]      divisor_o,
    input  wire logic                               div_done_i,
    input  wire logic signed [ofdm_pkg::IQ_W-1:0]   quotient_i_i,
    input  wire logic signed [ofdm_pkg::IQ_W-1:0]   quotient_q_i,
    output logic                                    flush_o,
    output logic                                    out_valid_o,
    input  wire logic                               out_ready_i,
    output ofdm_pkg::iq_sample_t                    out_sample_o,
    output logic                                    out_last_o
);
    import ofdm_pkg::*;
    import eq_ctrl_pkg::*;

    eq_state_t           state;
    logic                enable_d;
    logic [SC_IDX_W-1:0] sc_cnt;
    logic [SC_IDX_W-1:0] data_cnt;
    iq_sample_t          sample_q;
    logic                accept;

    // falling edge of enable restarts from the first training symbol
    assign flush_o = enable_d && !enable_i;

    assign lts.valid  = (state == S_LTS) && enable_i && in_valid_i && !chan_valid_i;
    assign lts.data   = in_sample_i;
    assign in_ready_o = enable_i && ((state == S_LTS) ? lts.ready : (state == S_ACCEPT));
    assign accept     = (state == S_ACCEPT) && enable_i && in_valid_i;

    assign rd_index_o    = sc_cnt;
    assign mult_start_o  = (state == S_WAIT_CHAN);
    assign mult_sample_o = sample_q;
    assign mult_chan_o   = chan_i;

    // product scaled up before the division by |h|^2
    assign div_start_o  = (state == S_MULT) && mult_done_i;
    assign dividend_i_o = {prod_i_i, {CONS_SCALE_SHIFT{1'b0}}};
    assign dividend_q_o = {prod_q_i, {CONS_SCALE_SHIFT{1'b0}}};
    assign divisor_o    = mag_sq_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            enable_d <= 1'b0;
        end else begin
            enable_d <= enable_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush_o) begin
            state       <= S_LTS;
            sc_cnt      <= '0;
            data_cnt    <= '0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
        end else begin
            case (state)
                S_LTS: begin
                    if (chan_valid_i) begin
                        state <= S_ACCEPT;
                    end
                end
                S_ACCEPT: begin
                    if (accept) begin
                        sc_cnt <= sc_cnt + 1'b1;
                        if (DATA_SC_MASK[sc_cnt]) begin
                            state <= S_WAIT_CHAN;
                        end
                    end
                end
                // channel read is on its way, multiply launches here
                S_WAIT_CHAN: state <= S_MULT;
                S_MULT: begin
                    if (mult_done_i) begin
                        state <= S_DIVIDE;
                    end
                end
                S_DIVIDE: begin
                    if (div_done_i) begin
                        out_valid_o <= 1'b1;
                        out_last_o  <= (data_cnt == SC_IDX_W'(NUM_DATA_SC - 1));
                        if (data_cnt == SC_IDX_W'(NUM_DATA_SC - 1)) begin
                            data_cnt <= '0;
                        end else begin
                            data_cnt <= data_cnt + 1'b1;
                        end
                        state <= S_OUTPUT;
                    end
                end
                S_OUTPUT: begin
                    if (out_ready_i) begin
                        out_valid_o <= 1'b0;
                        out_last_o  <= 1'b0;
                        state       <= S_ACCEPT;
                    end
                end
                default: state <= S_LTS;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            sample_q <= in_sample_i;
        end
        if ((state == S_DIVIDE) && div_done_i) begin
            out_sample_o <= {quotient_i_i, quotient_q_i};
        end
    end

    assert property (@(posedge clock) disable iff (reset || flush_o)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_sample_o));

endmodule

`default_nettype wire

//--- design/serial_divider.sv
`timescale 1ns/1ps
`default_nettype none

module serial_divider (
    input  wire logic                                clock,
    input  wire logic                                reset,
    input  wire logic                                start_i,
    input  wire logic signed [ofdm_pkg::QUO_W-1:0]   dividend_i,
    input  wire logic signed [ofdm_pkg::PROD_W-1:0]  divisor_i,
    output logic signed [ofdm_pkg::IQ_W-1:0]         quotient_o,
    output logic                                     busy_o,
    output logic                                     done_o
);
    import ofdm_pkg::*;
    import eq_ctrl_pkg::*;

    localparam int CNT_W = $clog2(DIV_LATENCY);

    logic [QUO_W-1:0]  quo;
    logic [PROD_W-1:0] dsr;
    logic [PROD_W:0]   rem;
    logic [PROD_W:0]   rem_shift;
    logic [CNT_W-1:0]  cnt;
    logic              negative;
    logic              zero_div;

    assign rem_shift = {rem[PROD_W-1:0], quo[QUO_W-1]};
    assign done_o    = busy_o && (cnt == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_o <= 1'b0;
            cnt    <= '0;
        end else if (start_i) begin
            busy_o <= 1'b1;
            cnt    <= CNT_W'(DIV_LATENCY - 1);
        end else if (busy_o) begin
            if (cnt == '0) begin
                busy_o <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // restoring division on magnitudes, one quotient bit per cycle
    always_ff @(posedge clock) begin
        if (start_i) begin
            quo      <= dividend_i[QUO_W-1] ? QUO_W'(-dividend_i) : dividend_i;
            dsr      <= divisor_i[PROD_W-1] ? PROD_W'(-divisor_i) : divisor_i;
            rem      <= '0;
            negative <= dividend_i[QUO_W-1] ^ divisor_i[PROD_W-1];
            zero_div <= (divisor_i == '0);
        end else if (busy_o && cnt != '0) begin
            if (rem_shift >= {1'b0, dsr}) begin
                rem <= rem_shift - {1'b0, dsr};
                quo <= {quo[QUO_W-2:0], 1'b1};
            end else begin
                rem <= rem_shift;
                quo <= {quo[QUO_W-2:0], 1'b0};
            end
        end
    end

    // sign, then clamp to the sample range
    always_comb begin
        if (zero_div) begin
            quotient_o = '0;
        end else if (negative) begin
            if (quo > QUO_W'(2 ** (IQ_W - 1))) begin
                quotient_o = {1'b1, {(IQ_W-1){1'b0}}};
            end else begin
                quotient_o = -IQ_W'(quo);
            end
        end else if (quo > QUO_W'(2 ** (IQ_W - 1) - 1)) begin
            quotient_o = {1'b0, {(IQ_W-1){1'b1}}};
        end else begin
            quotient_o = IQ_W'(quo);
        end
    end

    assert property (@(posedge clock) disable iff (reset) busy_o |-> !start_i);

endmodule

`default_nettype wire

//--- design/conj_mult.sv
`timescale 1ns/1ps
`default_nettype none

module conj_mult (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              start_i,
    input  wire ofdm_pkg::iq_sample_t              sample_i,
    input  wire ofdm_pkg::iq_sample_t              chan_i,
    output logic signed [ofdm_pkg::PROD_W-1:0]     prod_i_o,
    output logic signed [ofdm_pkg::PROD_W-1:0]     prod_q_o,
    output logic signed [ofdm_pkg::PROD_W-1:0]     mag_sq_o,
    output logic                                   done_o
);
    import ofdm_pkg::*;

    iq_sample_t a_q;
    iq_sample_t b_q;
    logic       stage1;

    always_ff @(posedge clock) begin
        if (reset) begin
            stage1 <= 1'b0;
            done_o <= 1'b0;
        end else begin
            stage1 <= start_i;
            done_o <= stage1;
        end
    end

    always_ff @(posedge clock) begin
        if (start_i) begin
            a_q <= sample_i;
            b_q <= chan_i;
        end
        // a * conj(b)
        prod_i_o <= PROD_W'(a_q.i) * PROD_W'(b_q.i) + PROD_W'(a_q.q) * PROD_W'(b_q.q);
        prod_q_o <= PROD_W'(a_q.q) * PROD_W'(b_q.i) - PROD_W'(a_q.i) * PROD_W'(b_q.q);
        mag_sq_o <= PROD_W'(b_q.i) * PROD_W'(b_q.i) + PROD_W'(b_q.q) * PROD_W'(b_q.q);
    end

endmodule

`default_nettype wire

//--- design/channel_estimator.sv
`timescale 1ns/1ps
`default_nettype none

module channel_estimator (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          flush_i,
    iq_stream_if.sink                          lts,
    input  wire logic [ofdm_pkg::SC_IDX_W-1:0] rd_index_i,
    output ofdm_pkg::iq_sample_t               chan_o,
    output logic                               chan_valid_o
);
    import ofdm_pkg::*;

    iq_sample_t ram [NUM_SC];

    logic [SC_IDX_W-1:0] wr_cnt;
    logic                second_pass;
    logic                complete;
    logic                accepting;
    logic                wr_en;
    iq_sample_t          stored;
    iq_sample_t          avg;
    iq_sample_t          wr_data;
    logic signed [IQ_W:0] sum_i;
    logic signed [IQ_W:0] sum_q;

    assign lts.ready    = accepting;
    assign chan_valid_o = complete;
    assign wr_en        = lts.valid && accepting;

    // average of both training symbols, sign fixed by the reference bit
    always_comb begin
        stored = ram[wr_cnt];
        sum_i  = stored.i + lts.data.i;
        sum_q  = stored.q + lts.data.q;
        avg.i  = sum_i[IQ_W:1];
        avg.q  = sum_q[IQ_W:1];
        if (LTS_REF[wr_cnt]) begin
            avg.i = -avg.i;
            avg.q = -avg.q;
        end
        wr_data = second_pass ? avg : lts.data;
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            ram[wr_cnt] <= wr_data;
        end
        chan_o <= ram[rd_index_i];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_cnt      <= '0;
            second_pass <= 1'b0;
            complete    <= 1'b0;
            accepting   <= 1'b0;
        end else if (flush_i) begin
            wr_cnt      <= '0;
            second_pass <= 1'b0;
            complete    <= 1'b0;
            accepting   <= 1'b1;
        end else begin
            if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == SC_IDX_W'(NUM_SC - 1)) begin
                    second_pass <= 1'b1;
                    if (second_pass) begin
                        complete  <= 1'b1;
                        accepting <= 1'b0;
                    end
                end
            end else if (!complete) begin
                accepting <= 1'b1;
            end
        end
    end

    // the controller stops sourcing training samples once the estimate is done
    assert property (@(posedge clock) disable iff (reset || flush_i)
        chan_valid_o |-> !lts.valid);

endmodule

`default_nettype wire

//--- design/iq_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface iq_stream_if;

    logic                 valid;
    logic                 ready;
    ofdm_pkg::iq_sample_t data;

    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

//--- design/eq_ctrl_pkg.sv
`default_nettype none

package eq_ctrl_pkg;

    typedef enum logic [2:0] {
        S_LTS,
        S_WAIT_CHAN,
        S_ACCEPT,
        S_MULT,
        S_DIVIDE,
        S_OUTPUT
    } eq_state_t;

    localparam int DIV_LATENCY = ofdm_pkg::QUO_W + 1;

endpackage

`default_nettype wire

//--- design/ofdm_pkg.sv
`default_nettype none

package ofdm_pkg;

    localparam int NUM_SC = 64;
    localparam int SC_IDX_W = 6;
    localparam int IQ_W = 16;
    localparam int NUM_DATA_SC = 48;

    // bit 0 is DC, bits 1..26 are +1..+26, bits 38..63 are -26..-1
    localparam logic [NUM_SC-1:0] SC_MASK =
        64'b1111111111111111111111111100000000000111111111111111111111111110;
    // pilots at -7, -21, +21, +7
    localparam logic [NUM_SC-1:0] PILOT_MASK =
        64'b0000001000000000000010000000000000000000001000000000000010000000;
    localparam logic [NUM_SC-1:0] DATA_SC_MASK = SC_MASK ^ PILOT_MASK;

    // reference bit per subcarrier, a set bit means the LTS value is -1
    localparam logic [NUM_SC-1:0] LTS_REF =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    localparam int CONS_SCALE_SHIFT = 10;
    localparam int PROD_W = 34;
    localparam int QUO_W = PROD_W + CONS_SCALE_SHIFT;

    typedef struct packed {
        logic signed [IQ_W-1:0] i;
        logic signed [IQ_W-1:0] q;
    } iq_sample_t;

endpackage

`default_nettype wire
